/* hw/rename_config.svh */
// ==============================
// rename config
// register counts and history depth for the rename subsystem
// ==============================

`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural and physical register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 64

// free list holds whatever is not architecturally mapped
`define FREE_DEPTH 32

// in-flight renames tracked for retire and squash
`define HIST_DEPTH 16

`endif

/* hw/rename_pkg.sv */
// ==============================
// rename package
// index types, history entry and enums shared by the rename blocks
// ==============================

`include "rename_config.svh"

package rename_pkg;

    // register and history indices
    typedef logic [$clog2(`PHYS_REGS)-1:0]  phys_t;
    typedef logic [$clog2(`ARCH_REGS)-1:0]  arch_t;
    typedef logic [$clog2(`HIST_DEPTH)-1:0] tag_t;

    // one rename record, 17 bits
    typedef struct packed {
        arch_t arch;
        phys_t new_phys;
        phys_t old_phys;
    } hist_entry_t;

    // squash walker
    typedef enum logic {WALK_IDLE, WALK_ACTIVE} walk_state_e;

    // winner on the shared release port
    typedef enum logic [1:0] {SRC_NONE, SRC_RETIRE, SRC_SQUASH} release_src_e;

endpackage

/* hw/alloc_if.sv */
// ==============================
// alloc_if
// one free-list allocation request and its answer
// ==============================

`timescale 1ns/1ps

interface alloc_if
    import rename_pkg::*;
();

    // request from rename, answer from the free list
    logic  req;
    logic  grant;
    phys_t phys;
    logic  empty;

    // history buffer asks
    modport requester (output req, input grant, input phys, input empty);

    // free list answers
    modport provider (input req, output grant, output phys, output empty);

    // map table only watches the result
    modport observer (input grant, input phys);

endinterface

/* hw/free_list.sv */
// ==============================
// free_list
// circular FIFO of free physical registers
// allocate from head, release at tail
// ==============================

`timescale 1ns/1ps

`include "rename_config.svh"

module free_list
    import rename_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    alloc_if.provider    alloc,
    input  logic         rel_valid_i,
    input  phys_t        rel_phys_i,
    output logic         full_o,
    output logic [6:0]   free_count_o
);

    localparam int PTR_W = $clog2(`FREE_DEPTH);
    localparam int CNT_W = $clog2(`FREE_DEPTH + 1);

    // ==============================
    // storage and pointers
    // ==============================
    phys_t              fifo_q [`FREE_DEPTH];
    logic [PTR_W-1:0]   head_q;
    logic [PTR_W-1:0]   tail_q;
    logic [CNT_W-1:0]   count_q;

    // no free regs left
    assign alloc.empty = (count_q == '0);
    assign full_o      = alloc.empty;

    // answer straight from the head slot
    // a release this cycle is not visible here yet
    assign alloc.grant = alloc.req && !alloc.empty;
    assign alloc.phys  = fifo_q[head_q];

    assign free_count_o = {{(7 - CNT_W){1'b0}}, count_q};

    // ==============================
    // pointer and count update
    // ==============================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q  <= '0;
            // tail wraps onto head when the list is full
            tail_q  <= '0;
            count_q <= CNT_W'(`FREE_DEPTH);
        end else begin
            if (alloc.grant) begin
                head_q <= head_q + PTR_W'(1);
            end
            if (rel_valid_i) begin
                tail_q <= tail_q + PTR_W'(1);
            end
            // net change is release minus grant
            count_q <= count_q + CNT_W'(rel_valid_i) - CNT_W'(alloc.grant);
        end
    end

    // fifo contents, initially the regs above the arch range
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `FREE_DEPTH; i++) begin
                fifo_q[i] <= phys_t'(`ARCH_REGS + i);
            end
        end else if (rel_valid_i) begin
            fifo_q[tail_q] <= rel_phys_i;
        end
    end

endmodule

/* hw/map_table.sv */
// ==============================
// map_table
// speculative arch to phys map
// rename write, squash restore, source lookup
// ==============================

`timescale 1ns/1ps

`include "rename_config.svh"

module map_table
    import rename_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    alloc_if.observer    alloc,
    input  arch_t        arch_dst_i,
    output phys_t        old_phys_o,
    input  logic         restore_valid_i,
    input  arch_t        restore_arch_i,
    input  phys_t        restore_phys_i,
    input  arch_t        src_arch_i,
    output phys_t        src_phys_o
);

    phys_t map_q [`ARCH_REGS];

    // previous mapping of the destination, same cycle as rename
    assign old_phys_o = map_q[arch_dst_i];

    // source lookup reads the current map, no bypass
    assign src_phys_o = map_q[src_arch_i];

    // ==============================
    // map update
    // ==============================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // identity map out of reset
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= phys_t'(i);
            end
        end else if (alloc.grant) begin
            map_q[arch_dst_i] <= alloc.phys;
        end else if (restore_valid_i) begin
            // only during a walk, renames are refused then
            map_q[restore_arch_i] <= restore_phys_i;
        end
    end

endmodule

/* hw/history_buffer.sv */
// ==============================
// history_buffer
// in-order rename history
// retire pops the oldest, squash walk pops the youngest
// ==============================

`timescale 1ns/1ps

`include "rename_config.svh"

module history_buffer
    import rename_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          rename_i,
    input  arch_t         arch_dst_i,
    input  phys_t         old_phys_i,
    alloc_if.requester    alloc,
    output tag_t          tag_o,
    input  logic          commit_i,
    input  logic          flush_i,
    input  tag_t          flush_tag_i,
    output logic          retire_valid_o,
    output phys_t         retire_phys_o,
    output logic          squash_valid_o,
    output phys_t         squash_phys_o,
    input  logic          squash_grant_i,
    output logic          restore_valid_o,
    output arch_t         restore_arch_o,
    output phys_t         restore_phys_o,
    output logic          walk_busy_o
);

    localparam int CNT_W = $clog2(`HIST_DEPTH + 1);

    hist_entry_t       hist_q [`HIST_DEPTH];
    tag_t              head_q;
    tag_t              tail_q;
    logic [CNT_W-1:0]  count_q;
    walk_state_e       state_q;
    tag_t              walk_tag_q;
    tag_t              youngest;
    tag_t              youngest_next;
    logic              full;

    assign full     = (count_q == CNT_W'(`HIST_DEPTH));
    assign youngest = tail_q - tag_t'(1);

    // youngest entry after this edge, counting a rename in this cycle
    assign youngest_next = alloc.grant ? tail_q : youngest;

    // ==============================
    // rename side
    // ==============================
    assign alloc.req   = rename_i && !full && (state_q == WALK_IDLE);
    assign tag_o       = tail_q;
    assign walk_busy_o = (state_q == WALK_ACTIVE);

    // retire frees the old mapping of the oldest entry
    assign retire_valid_o = commit_i && (count_q != '0);
    assign retire_phys_o  = hist_q[head_q].old_phys;

    // squash frees the new reg and restores the old one
    assign squash_valid_o  = walk_busy_o;
    assign squash_phys_o   = hist_q[youngest].new_phys;
    assign restore_valid_o = squash_grant_i;
    assign restore_arch_o  = hist_q[youngest].arch;
    assign restore_phys_o  = hist_q[youngest].old_phys;

    // entry payload, written on grant
    always_ff @(posedge clock) begin
        if (alloc.grant) begin
            hist_q[tail_q] <= '{arch: arch_dst_i, new_phys: alloc.phys, old_phys: old_phys_i};
        end
    end

    // ==============================
    // pointers and walker
    // ==============================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            state_q    <= WALK_IDLE;
            walk_tag_q <= '0;
        end else begin
            if (retire_valid_o) begin
                head_q <= head_q + tag_t'(1);
            end
            // push and squash never coincide
            if (alloc.grant) begin
                tail_q <= tail_q + tag_t'(1);
            end else if (squash_grant_i) begin
                tail_q <= youngest;
            end
            count_q <= count_q + CNT_W'(alloc.grant) - CNT_W'(retire_valid_o)
                       - CNT_W'(squash_grant_i);
            case (state_q)
                WALK_IDLE: begin
                    // nothing younger than the tag means no walk
                    if (flush_i && (count_q != '0 || alloc.grant) &&
                        youngest_next != flush_tag_i) begin
                        state_q    <= WALK_ACTIVE;
                        walk_tag_q <= flush_tag_i;
                    end
                end
                WALK_ACTIVE: begin
                    // stop once the tagged entry is the youngest left
                    if (squash_grant_i && (youngest - tag_t'(1)) == walk_tag_q) begin
                        state_q <= WALK_IDLE;
                    end
                end
                default: state_q <= WALK_IDLE;
            endcase
        end
    end

endmodule

/* hw/release_arbiter.sv */
// ==============================
// release_arbiter
// fixed priority, retire over squash, onto one release port
// ==============================

`timescale 1ns/1ps

module release_arbiter
    import rename_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   retire_valid_i,
    input  phys_t  retire_phys_i,
    input  logic   squash_valid_i,
    input  phys_t  squash_phys_i,
    output logic   squash_grant_o,
    output logic   rel_valid_o,
    output phys_t  rel_phys_o
);

    release_src_e win_src;

    // retire always wins, walker stalls a cycle
    always_comb begin
        if (retire_valid_i) begin
            win_src = SRC_RETIRE;
        end else if (squash_valid_i) begin
            win_src = SRC_SQUASH;
        end else begin
            win_src = SRC_NONE;
        end
    end

    assign squash_grant_o = (win_src == SRC_SQUASH);
    assign rel_valid_o    = (win_src != SRC_NONE);
    assign rel_phys_o     = (win_src == SRC_RETIRE) ? retire_phys_i : squash_phys_i;

endmodule

/* hw/rename_top.sv */
// ==============================
// rename_top
// rename subsystem, free list, map, history, release arbiter
// ==============================

`timescale 1ns/1ps

module rename_top
    import rename_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         rename_i,
    input  arch_t        arch_dst_i,
    output logic         rename_ok_o,
    output phys_t        new_phys_o,
    output phys_t        old_phys_o,
    output tag_t         tag_o,
    input  arch_t        src_arch_i,
    output phys_t        src_phys_o,
    input  logic         commit_i,
    input  logic         flush_i,
    input  tag_t         flush_tag_i,
    output logic         walk_busy_o,
    output logic         full_o,
    output logic [6:0]   free_count_o
);

    // allocation bundle
    alloc_if alloc ();

    // release and restore paths
    logic   retire_valid;
    phys_t  retire_phys;
    logic   squash_valid;
    phys_t  squash_phys;
    logic   squash_grant;
    logic   rel_valid;
    phys_t  rel_phys;
    logic   restore_valid;
    arch_t  restore_arch;
    phys_t  restore_phys;

    // rename result is the free list answer
    assign rename_ok_o = alloc.grant;
    assign new_phys_o  = alloc.phys;

    free_list u_free_list (
        .clock        (clock),
        .reset        (reset),
        .alloc        (alloc.provider),
        .rel_valid_i  (rel_valid),
        .rel_phys_i   (rel_phys),
        .full_o       (full_o),
        .free_count_o (free_count_o)
    );

    map_table u_map_table (
        .clock           (clock),
        .reset           (reset),
        .alloc           (alloc.observer),
        .arch_dst_i      (arch_dst_i),
        .old_phys_o      (old_phys_o),
        .restore_valid_i (restore_valid),
        .restore_arch_i  (restore_arch),
        .restore_phys_i  (restore_phys),
        .src_arch_i      (src_arch_i),
        .src_phys_o      (src_phys_o)
    );

    history_buffer u_history (
        .clock           (clock),
        .reset           (reset),
        .rename_i        (rename_i),
        .arch_dst_i      (arch_dst_i),
        .old_phys_i      (old_phys_o),
        .alloc           (alloc.requester),
        .tag_o           (tag_o),
        .commit_i        (commit_i),
        .flush_i         (flush_i),
        .flush_tag_i     (flush_tag_i),
        .retire_valid_o  (retire_valid),
        .retire_phys_o   (retire_phys),
        .squash_valid_o  (squash_valid),
        .squash_phys_o   (squash_phys),
        .squash_grant_i  (squash_grant),
        .restore_valid_o (restore_valid),
        .restore_arch_o  (restore_arch),
        .restore_phys_o  (restore_phys),
        .walk_busy_o     (walk_busy_o)
    );

    release_arbiter u_arb (
        .clock          (clock),
        .reset          (reset),
        .retire_valid_i (retire_valid),
        .retire_phys_i  (retire_phys),
        .squash_valid_i (squash_valid),
        .squash_phys_i  (squash_phys),
        .squash_grant_o (squash_grant),
        .rel_valid_o    (rel_valid),
        .rel_phys_o     (rel_phys)
    );

endmodule

/* verification/rename_tb.sv */
// ==============================
// rename_tb
// random rename, commit and flush traffic against a reference model
// ==============================

`timescale 1ns/1ps

`include "rename_config.svh"

module rename_tb
    import rename_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 8;
    localparam int RAND_CYCLES     = 900;
    localparam int DRAIN_MARGIN    = 76;
    // twice the expected run length, 2000 cycles
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + DRAIN_MARGIN);

    typedef struct {
        arch_t arch;
        phys_t new_p;
        phys_t old_p;
        tag_t  tag;
    } model_entry_t;

    logic clock, reset;
    logic rename_i, rename_ok_o, commit_i, flush_i, walk_busy_o, full_o;
    arch_t arch_dst_i, src_arch_i;
    phys_t new_phys_o, old_phys_o, src_phys_o;
    tag_t tag_o, flush_tag_i;
    logic [6:0] free_count_o;

    // ==============================
    // reference model state
    // ==============================
    phys_t exp_map [`ARCH_REGS];
    phys_t free_q [$];
    model_entry_t hist_q [$];
    tag_t tail_tag, walk_tag;
    logic walking;
    // expected outputs, refreshed on every falling edge
    logic exp_ok, exp_busy, exp_hist_full;
    phys_t exp_new, exp_old, exp_src;
    tag_t exp_tag;
    int exp_count;

    rename_top u_dut (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic report_error(input string msg);
        $display("FAIL at time %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic init_model();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            exp_map[i] = phys_t'(i);
        end
        free_q.delete();
        // free FIFO starts with the regs above the arch range
        for (int i = 0; i < `FREE_DEPTH; i++) begin
            free_q.push_back(phys_t'(`ARCH_REGS + i));
        end
        hist_q.delete();
        tail_tag = '0;
        walk_tag = '0;
        walking = 1'b0;
    endtask

    // position of the flush target in the model history
    function automatic int tagged_index();
        foreach (hist_q[i]) begin
            if (hist_q[i].tag == walk_tag) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic compute_expected();
        exp_ok = rename_i && (hist_q.size() < `HIST_DEPTH) && !walking &&
                 (free_q.size() != 0);
        exp_new = (free_q.size() != 0) ? free_q[0] : '0;
        exp_old = exp_map[arch_dst_i];
        exp_src = exp_map[src_arch_i];
        exp_tag = tail_tag;
        exp_count = free_q.size();
        exp_busy = walking;
        exp_hist_full = (hist_q.size() == `HIST_DEPTH);
    endtask

    // one clock of rename, retire or squash step, then flush start
    task automatic step_model();
        model_entry_t e;
        logic was_walking;
        logic retire;
        was_walking = walking;
        retire = commit_i && (hist_q.size() != 0);
        if (exp_ok) begin
            e.arch = arch_dst_i;
            e.new_p = free_q.pop_front();
            e.old_p = exp_map[arch_dst_i];
            e.tag = tail_tag;
            hist_q.push_back(e);
            exp_map[arch_dst_i] = e.new_p;
            tail_tag = tail_tag + tag_t'(1);
        end
        // retire owns the release port, walker waits
        if (retire) begin
            e = hist_q.pop_front();
            free_q.push_back(e.old_p);
        end else if (was_walking) begin
            e = hist_q.pop_back();
            exp_map[e.arch] = e.old_p;
            free_q.push_back(e.new_p);
            tail_tag = e.tag;
            if (hist_q[$].tag == walk_tag) walking = 1'b0;
        end
        if (!was_walking && flush_i && hist_q.size() != 0 &&
            hist_q[$].tag != flush_tag_i) begin
            walking = 1'b1;
            walk_tag = flush_tag_i;
        end
    endtask

    always @(posedge clock) begin
        if (!reset) step_model();
    end

    task automatic drive_random();
        rename_i = ($urandom % 4) != 0;
        arch_dst_i = arch_t'($urandom);
        src_arch_i = arch_t'($urandom);
        commit_i = 1'b0;
        flush_i = 1'b0;
        if (walk_busy_o) begin
            // commit only entries older than the flush target
            if (tagged_index() > 0 && ($urandom % 2) == 0) begin
                commit_i = 1'b1;
            end
            if (($urandom % 8) == 0) begin
                flush_i = 1'b1;
                flush_tag_i = tag_t'($urandom);
            end
        end else if (($urandom % 10) == 0 && hist_q.size() != 0) begin
            rename_i = 1'b0;
            flush_i = 1'b1;
            flush_tag_i = hist_q[$urandom % hist_q.size()].tag;
        end else begin
            commit_i = ($urandom % 5) == 0;
        end
    endtask

    task automatic drain_cycle();
        rename_i = 1'b0;
        flush_i = 1'b0;
        src_arch_i = arch_t'($urandom);
        commit_i = walk_busy_o ? (tagged_index() > 0) : (hist_q.size() != 0);
    endtask

    // ==============================
    // checks against the model
    // ==============================
    assert property (@(posedge clock) disable iff (reset) rename_ok_o == exp_ok)
        else report_error($sformatf("rename_ok_o is %0b, expected %0b", rename_ok_o, exp_ok));
    assert property (@(posedge clock) disable iff (reset) exp_ok |-> new_phys_o == exp_new)
        else report_error($sformatf("new_phys_o is %0d, expected %0d", new_phys_o, exp_new));
    assert property (@(posedge clock) disable iff (reset) exp_ok |-> tag_o == exp_tag)
        else report_error($sformatf("tag_o is %0d, expected %0d", tag_o, exp_tag));
    assert property (@(posedge clock) disable iff (reset) old_phys_o == exp_old)
        else report_error($sformatf("old_phys_o is %0d, expected %0d", old_phys_o, exp_old));
    assert property (@(posedge clock) disable iff (reset) src_phys_o == exp_src)
        else report_error($sformatf("src_phys_o is %0d, expected %0d", src_phys_o, exp_src));
    assert property (@(posedge clock) disable iff (reset) free_count_o == 7'(exp_count))
        else report_error($sformatf("free_count_o is %0d, expected %0d", free_count_o, exp_count));
    assert property (@(posedge clock) disable iff (reset) full_o == (exp_count == 0))
        else report_error("full_o does not match an empty free list");
    assert property (@(posedge clock) disable iff (reset) walk_busy_o == exp_busy)
        else report_error($sformatf("walk_busy_o is %0b, expected %0b", walk_busy_o, exp_busy));
    // no renames while walking or with 16 entries in flight
    assert property (@(posedge clock) disable iff (reset) walk_busy_o |-> !rename_ok_o)
        else report_error("rename accepted during a squash walk");
    assert property (@(posedge clock) disable iff (reset) exp_hist_full |-> !rename_ok_o)
        else report_error("rename accepted with a full history");

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(33401));
        clock = 1'b0;
        reset = 1'b1;
        rename_i = 1'b0;
        arch_dst_i = '0;
        src_arch_i = '0;
        commit_i = 1'b0;
        flush_i = 1'b0;
        flush_tag_i = '0;
        init_model();
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        assert (free_count_o == 7'd32 && !full_o && !walk_busy_o && !rename_ok_o)
            else report_error("outputs differ from their reset values");
        // back to back renames take 32, 33 and on in order
        for (int i = 0; i < DIRECTED_CYCLES; i++) begin
            rename_i = 1'b1;
            arch_dst_i = arch_t'(i * 3);
            src_arch_i = arch_t'(i);
            compute_expected();
            @(negedge clock);
        end
        for (int i = 0; i < RAND_CYCLES; i++) begin
            drive_random();
            compute_expected();
            @(negedge clock);
        end
        // retire everything and let any walk finish
        while (walk_busy_o || hist_q.size() != 0) begin
            drain_cycle();
            compute_expected();
            @(negedge clock);
        end
        commit_i = 1'b0;
        compute_expected();
        @(negedge clock);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* sources.f */
+incdir+hw
hw/rename_pkg.sv
hw/alloc_if.sv
hw/free_list.sv
hw/map_table.sv
hw/history_buffer.sv
hw/release_arbiter.sv
hw/rename_top.sv
verification/rename_tb.sv
